/* sources.f */
+incdir+hdl
+incdir+test
hdl/stat_pkg.sv
hdl/stat_slot.sv
hdl/stat_arbiter.sv
hdl/stat_counter_bank.sv
hdl/port_reset_ctrl.sv
hdl/stat_collector_top.sv
test/tb_stat_collector.sv

/* run_sim.sh */
#!/bin/sh
# build and run the statistics collector simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module tb_stat_collector \
    -o sim_stat_collector

status=0
./obj_dir/sim_stat_collector > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0

/* test/tb_stat_tasks.svh */
// testbench driver and checker tasks

`ifndef TB_STAT_TASKS_SVH
`define TB_STAT_TASKS_SVH

// ########################################
// failure handling and checks
// ########################################

task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first failure");
endtask

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
    if (actual !== expected) begin
        $display("ERROR at %0d ns: %s, got 0x%08h, expected 0x%08h",
                 $time, msg, actual, expected);
        abort_run();
    end
endtask

// counters wrap at 2^32 like the bank
task automatic add_to_model(input int idx, input stat_pkg::stat_inc_t inc);
    model[idx] = model[idx] + 32'(inc);
endtask

task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_125mhz);
endtask

// ########################################
// drivers
// ########################################

// single-cycle strobe on one port
task automatic send_incr(input int port, input stat_pkg::stat_local_id_t id,
                         input stat_pkg::stat_inc_t inc);
    @(posedge clk_125mhz);
    stat_valid[port] <= 1'b1;
    stat_id[port]    <= id;
    stat_inc[port]   <= inc;
    @(posedge clk_125mhz);
    stat_valid[port] <= 1'b0;
endtask

task automatic read_counter(input stat_pkg::stat_id_t addr,
                            output stat_pkg::stat_count_t data);
    logic got;
    got = 1'b0;
    data = '0;
    @(posedge clk_125mhz);
    rd_valid <= 1'b1;
    rd_addr  <= addr;
    @(posedge clk_125mhz);
    rd_valid <= 1'b0;
    for (int waited = 0; waited < WAIT_LIMIT && !got; waited++) begin
        @(negedge clk_125mhz);
        got = rd_data_valid;
    end
    if (!got) begin
        $display("read of counter %0d got no response in time", addr);
        abort_run();
    end else begin
        data = rd_data;
    end
endtask

task automatic compare_all_counters(input string tag);
    stat_pkg::stat_count_t data;
    for (int i = 0; i < CNT_NUM; i++) begin
        read_counter(stat_pkg::stat_id_t'(i), data);
        check_value(data, model[i], $sformatf("%s, counter %0d", tag, i));
    end
endtask

// cycles counts rising edges since the caller's drive edge
task automatic wait_resetl(input logic [`STAT_PORT_CNT-1:0] expected, input int max_cycles,
                           output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles <= max_cycles) begin
        @(negedge clk_125mhz);
        if (port_resetl === expected) begin
            seen = 1'b1;
        end else begin
            cycles++;
        end
    end
    if (!seen) begin
        $display("port reset did not reach %b within %0d cycles", expected, max_cycles);
        abort_run();
    end
endtask

`endif

/* test/tb_stat_collector.sv */
// statistics collector testbench

`timescale 1ns/1ps
`default_nettype none

`include "stat_consts.svh"

module tb_stat_collector;

    localparam int CNT_NUM    = `STAT_PORT_CNT * `STAT_PER_PORT;
    localparam int WAIT_LIMIT = 64;
    localparam int ROUNDS     = 200;

    logic                                           clk_125mhz = 1'b0;
    logic                                           arst_n;
    logic [`STAT_PORT_CNT-1:0]                      stat_valid;
    stat_pkg::stat_local_id_t [`STAT_PORT_CNT-1:0]  stat_id;
    stat_pkg::stat_inc_t [`STAT_PORT_CNT-1:0]       stat_inc;
    logic                                           rd_valid;
    stat_pkg::stat_id_t                             rd_addr;
    logic                                           rd_data_valid;
    stat_pkg::stat_count_t                          rd_data;
    logic                                           init_busy;
    logic                                           pll_locked;
    logic [`STAT_PORT_CNT-1:0]                      port_resetl;

    // expected counter values
    logic [`STAT_COUNT_W-1:0]  model [CNT_NUM];
    int                        seed;

    // 125 MHz
    always #4 clk_125mhz = ~clk_125mhz;

    stat_collector_top i_dut (
        .clk_125mhz_i    (clk_125mhz),
        .arst_n_i        (arst_n),
        .stat_valid_i    (stat_valid),
        .stat_id_i       (stat_id),
        .stat_inc_i      (stat_inc),
        .rd_valid_i      (rd_valid),
        .rd_addr_i       (rd_addr),
        .rd_data_valid_o (rd_data_valid),
        .rd_data_o       (rd_data),
        .init_busy_i     (init_busy),
        .pll_locked_i    (pll_locked),
        .port_resetl_o   (port_resetl)
    );

    `include "tb_stat_tasks.svh"

    // ########################################
    // directed tests
    // ########################################

    task automatic verify_reset_state();
        @(negedge clk_125mhz);
        check_value(32'(port_resetl), '0, "port reset low after reset with init busy");
        // longer than sync plus hold
        idle_cycles(`STAT_SYNC_STAGES + `STAT_RESET_HOLD + 4);
        @(negedge clk_125mhz);
        check_value(32'(port_resetl), '0, "port reset still low while init busy");
        compare_all_counters("reset state");
    endtask

    task automatic single_increments();
        stat_pkg::stat_local_id_t  id;
        stat_pkg::stat_inc_t       inc;
        for (int p = 0; p < `STAT_PORT_CNT; p++) begin
            id  = stat_pkg::stat_local_id_t'(2 * p + 1);
            inc = stat_pkg::stat_inc_t'($random(seed));
            send_incr(p, id, inc);
            add_to_model(p * `STAT_PER_PORT + int'(id), inc);
            // well past the strobe to counter latency
            idle_cycles(`STAT_PORT_CNT + 4);
        end
        compare_all_counters("single increment");
    endtask

    task automatic simultaneous_strobes();
        stat_pkg::stat_local_id_t  id;
        stat_pkg::stat_inc_t       inc;
        for (int r = 0; r < ROUNDS; r++) begin
            @(posedge clk_125mhz);
            for (int p = 0; p < `STAT_PORT_CNT; p++) begin
                id  = stat_pkg::stat_local_id_t'($random(seed));
                inc = stat_pkg::stat_inc_t'($random(seed));
                stat_valid[p] <= 1'b1;
                stat_id[p]    <= id;
                stat_inc[p]   <= inc;
                add_to_model(p * `STAT_PER_PORT + int'(id), inc);
            end
            @(posedge clk_125mhz);
            stat_valid <= '0;
            // one strobe per port every port-count cycles
            idle_cycles(`STAT_PORT_CNT - 2);
        end
        idle_cycles(`STAT_PORT_CNT + 4);
        compare_all_counters("simultaneous strobes");
    endtask

    task automatic back_to_back_reads();
        for (int i = 0; i <= CNT_NUM; i++) begin
            @(posedge clk_125mhz);
            if (i < CNT_NUM) begin
                rd_valid <= 1'b1;
                rd_addr  <= stat_pkg::stat_id_t'(i);
            end else begin
                rd_valid <= 1'b0;
            end
            @(negedge clk_125mhz);
            if (i == 0) begin
                check_value(32'(rd_data_valid), 0, "no response before first read");
            end else begin
                check_value(32'(rd_data_valid), 1, $sformatf("response for read %0d", i - 1));
                check_value(rd_data, model[i - 1], $sformatf("back-to-back read %0d", i - 1));
            end
        end
        @(negedge clk_125mhz);
        check_value(32'(rd_data_valid), 0, "no response after last read");
    endtask

    task automatic port_reset_sequence();
        int cycles;
        check_value(32'(port_resetl), '0, "port reset low before init done");
        @(posedge clk_125mhz);
        init_busy <= 1'b0;
        wait_resetl('1, `STAT_SYNC_STAGES + `STAT_RESET_HOLD + 2, cycles);
        check_value(32'(cycles >= `STAT_RESET_HOLD), 1, "port reset released before hold time");
        @(posedge clk_125mhz);
        pll_locked <= 1'b0;
        wait_resetl('0, `STAT_SYNC_STAGES + 1, cycles);
        @(posedge clk_125mhz);
        pll_locked <= 1'b1;
        wait_resetl('1, `STAT_SYNC_STAGES + `STAT_RESET_HOLD + 2, cycles);
        check_value(32'(cycles >= `STAT_RESET_HOLD), 1, "port reset released early on relock");
    endtask

    // ########################################
    // test sequence
    // ########################################

    initial begin
        seed       = 32'h453;
        arst_n     = 1'b0;
        stat_valid = '0;
        stat_id    = '0;
        stat_inc   = '0;
        rd_valid   = 1'b0;
        rd_addr    = '0;
        // init done and pll locked, only arst_n holds the port reset
        init_busy  = 1'b0;
        pll_locked = 1'b1;
        for (int i = 0; i < CNT_NUM; i++) begin
            model[i] = '0;
        end
        repeat (8) begin
            @(negedge clk_125mhz);
            check_value(32'(port_resetl), '0, "port reset low during reset");
        end
        @(posedge clk_125mhz);
        arst_n    <= 1'b1;
        init_busy <= 1'b1;
        verify_reset_state();
        single_increments();
        simultaneous_strobes();
        back_to_back_reads();
        port_reset_sequence();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/stat_collector_top.sv */
// statistics collector top level

`timescale 1ns/1ps
`default_nettype none

`include "stat_consts.svh"

module stat_collector_top (
    input  wire logic                                        clk_125mhz_i,
    input  wire logic                                        arst_n_i,

    // per-port increment strobes
    input  wire logic [`STAT_PORT_CNT-1:0]                   stat_valid_i,
    input  stat_pkg::stat_local_id_t [`STAT_PORT_CNT-1:0]    stat_id_i,
    input  stat_pkg::stat_inc_t [`STAT_PORT_CNT-1:0]         stat_inc_i,

    // counter read port
    input  wire logic                                        rd_valid_i,
    input  stat_pkg::stat_id_t                               rd_addr_i,
    output logic                                             rd_data_valid_o,
    output stat_pkg::stat_count_t                            rd_data_o,

    // link reset sequencing
    input  wire logic                                        init_busy_i,
    input  wire logic                                        pll_locked_i,
    output logic [`STAT_PORT_CNT-1:0]                        port_resetl_o
);

    logic [`STAT_PORT_CNT-1:0]   slot_pending;
    logic [`STAT_PORT_CNT-1:0]   slot_grant;
    stat_pkg::stat_local_upd_t   slot_upd [`STAT_PORT_CNT];

    logic                        upd_valid;
    stat_pkg::stat_update_t      upd;

    // ########################################
    // per-port slots
    // ########################################

    for (genvar p = 0; p < `STAT_PORT_CNT; p++) begin : g_slot

        stat_pkg::stat_local_upd_t slot_in;

        assign slot_in.id  = stat_id_i[p];
        assign slot_in.inc = stat_inc_i[p];

        stat_slot i_slot (
            .clk_125mhz_i (clk_125mhz_i),
            .arst_n_i     (arst_n_i),
            .strobe_i     (stat_valid_i[p]),
            .upd_i        (slot_in),
            .grant_i      (slot_grant[p]),
            .pending_o    (slot_pending[p]),
            .upd_o        (slot_upd[p])
        );

    end

    // ########################################
    // merge and count
    // ########################################

    stat_arbiter i_arbiter (
        .clk_125mhz_i (clk_125mhz_i),
        .arst_n_i     (arst_n_i),
        .pending_i    (slot_pending),
        .slot_upd_i   (slot_upd),
        .grant_o      (slot_grant),
        .upd_valid_o  (upd_valid),
        .upd_o        (upd)
    );

    stat_counter_bank i_counter_bank (
        .clk_125mhz_i    (clk_125mhz_i),
        .arst_n_i        (arst_n_i),
        .upd_valid_i     (upd_valid),
        .upd_i           (upd),
        .rd_valid_i      (rd_valid_i),
        .rd_addr_i       (rd_addr_i),
        .rd_data_valid_o (rd_data_valid_o),
        .rd_data_o       (rd_data_o)
    );

    // port resets
    port_reset_ctrl i_port_reset_ctrl (
        .clk_125mhz_i  (clk_125mhz_i),
        .arst_n_i      (arst_n_i),
        .init_busy_i   (init_busy_i),
        .pll_locked_i  (pll_locked_i),
        .port_resetl_o (port_resetl_o)
    );

endmodule

`default_nettype wire

/* hdl/port_reset_ctrl.sv */
// ethernet port reset sequencer

`timescale 1ns/1ps
`default_nettype none

`include "stat_consts.svh"

module port_reset_ctrl (
    input  wire logic                       clk_125mhz_i,
    input  wire logic                       arst_n_i,

    input  wire logic                       init_busy_i,
    input  wire logic                       pll_locked_i,

    output logic [`STAT_PORT_CNT-1:0]       port_resetl_o
);

    localparam int HOLD_W = $clog2(`STAT_RESET_HOLD + 1);

    logic [`STAT_SYNC_STAGES-1:0]  lock_sync_q;
    logic                          hold_cond;
    logic [HOLD_W-1:0]             hold_cnt_q;
    logic                          resetl_q;

    // pll lock comes from the clock synthesizer, not from this domain
    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lock_sync_q <= '0;
        end else begin
            lock_sync_q <= {lock_sync_q[`STAT_SYNC_STAGES-2:0], pll_locked_i};
        end
    end

    // init busy is already on the 125 MHz clock
    assign hold_cond = init_busy_i | ~lock_sync_q[`STAT_SYNC_STAGES-1];

    // counter loads hold-1 so release lands exactly hold cycles later
    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_cnt_q <= HOLD_W'(`STAT_RESET_HOLD - 1);
            resetl_q   <= 1'b0;
        end else if (hold_cond) begin
            hold_cnt_q <= HOLD_W'(`STAT_RESET_HOLD - 1);
            resetl_q   <= 1'b0;
        end else if (hold_cnt_q != '0) begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
        end else begin
            resetl_q   <= 1'b1;
        end
    end

    // same reset for every port
    assign port_resetl_o = {`STAT_PORT_CNT{resetl_q}};

endmodule

`default_nettype wire

/* hdl/stat_counter_bank.sv */
// statistic counter bank

`timescale 1ns/1ps
`default_nettype none

`include "stat_consts.svh"

module stat_counter_bank (
    input  wire logic                  clk_125mhz_i,
    input  wire logic                  arst_n_i,

    // update stream from the arbiter
    input  wire logic                  upd_valid_i,
    input  stat_pkg::stat_update_t     upd_i,

    // read port
    input  wire logic                  rd_valid_i,
    input  stat_pkg::stat_id_t         rd_addr_i,
    output logic                       rd_data_valid_o,
    output stat_pkg::stat_count_t      rd_data_o
);

    localparam int CNT_NUM = `STAT_PORT_CNT * `STAT_PER_PORT;

    stat_pkg::stat_count_t  cnt_q [CNT_NUM];
    stat_pkg::stat_count_t  cnt_inc;
    logic                   rd_valid_q;
    stat_pkg::stat_count_t  rd_data_q;

    // zero-extend the increment to counter width
    assign cnt_inc = stat_pkg::stat_count_t'(upd_i.inc);

    // ########################################
    // counter accumulation
    // ########################################

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < CNT_NUM; i++) begin
                cnt_q[i] <= '0;
            end
        end else if (upd_valid_i) begin
            // wraps at 2^32
            cnt_q[upd_i.id] <= cnt_q[upd_i.id] + cnt_inc;
        end
    end

    // ########################################
    // registered read
    // ########################################

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_valid_i;
        end
    end

    // sampled before any same-cycle update lands,
    // so a colliding read sees the old count
    always_ff @(posedge clk_125mhz_i) begin
        if (rd_valid_i) begin
            rd_data_q <= cnt_q[rd_addr_i];
        end
    end

    assign rd_data_valid_o = rd_valid_q;
    assign rd_data_o       = rd_data_q;

endmodule

`default_nettype wire

/* hdl/stat_arbiter.sv */
// round-robin statistic update arbiter

`timescale 1ns/1ps
`default_nettype none

`include "stat_consts.svh"

module stat_arbiter (
    input  wire logic                       clk_125mhz_i,
    input  wire logic                       arst_n_i,

    // slot side
    input  wire logic [`STAT_PORT_CNT-1:0]  pending_i,
    input  stat_pkg::stat_local_upd_t       slot_upd_i [`STAT_PORT_CNT],
    output logic [`STAT_PORT_CNT-1:0]       grant_o,

    // merged update stream
    output logic                            upd_valid_o,
    output stat_pkg::stat_update_t          upd_o
);

    localparam int PORT_IDX_W = $clog2(`STAT_PORT_CNT);

    logic [PORT_IDX_W-1:0]   last_q;
    logic [PORT_IDX_W-1:0]   gnt_idx;
    logic                    gnt_valid;
    stat_pkg::stat_id_t      gnt_id;
    logic                    upd_valid_q;
    stat_pkg::stat_update_t  upd_q;

    // ########################################
    // next pending port after the last grant
    // ########################################

    always_comb begin : rr_sel
        int idx;
        grant_o   = '0;
        gnt_valid = 1'b0;
        gnt_idx   = last_q;
        for (int i = 1; i <= `STAT_PORT_CNT; i++) begin
            idx = (int'(last_q) + i) % `STAT_PORT_CNT;
            if (!gnt_valid && pending_i[idx]) begin
                gnt_valid = 1'b1;
                gnt_idx   = PORT_IDX_W'(idx);
            end
        end
        if (gnt_valid) begin
            grant_o[gnt_idx] = 1'b1;
        end
    end

    // port base plus local index
    assign gnt_id = stat_pkg::stat_id_t'(gnt_idx) * stat_pkg::stat_id_t'(`STAT_PER_PORT)
                  + stat_pkg::stat_id_t'(slot_upd_i[gnt_idx].id);

    // ########################################
    // update register
    // ########################################

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // port 0 is served first after reset
            last_q      <= PORT_IDX_W'(`STAT_PORT_CNT - 1);
            upd_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= gnt_valid;
            if (gnt_valid) begin
                last_q <= gnt_idx;
            end
        end
    end

    always_ff @(posedge clk_125mhz_i) begin
        if (gnt_valid) begin
            upd_q.id  <= gnt_id;
            upd_q.inc <= slot_upd_i[gnt_idx].inc;
        end
    end

    assign upd_valid_o = upd_valid_q;
    assign upd_o       = upd_q;

endmodule

`default_nettype wire

/* hdl/stat_slot.sv */
// per-port statistic holding slot

`timescale 1ns/1ps
`default_nettype none

module stat_slot (
    input  wire logic                     clk_125mhz_i,
    input  wire logic                     arst_n_i,

    // increment report from the port
    input  wire logic                     strobe_i,
    input  stat_pkg::stat_local_upd_t     upd_i,

    // towards the arbiter
    input  wire logic                     grant_i,
    output logic                          pending_o,
    output stat_pkg::stat_local_upd_t     upd_o
);

    logic                       pending_q;
    stat_pkg::stat_local_upd_t  upd_q;

    // a strobe wins over a grant in the same cycle,
    // the slot simply reloads with the new report
    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else if (strobe_i) begin
            pending_q <= 1'b1;
        end else if (grant_i) begin
            pending_q <= 1'b0;
        end
    end

    // payload capture
    always_ff @(posedge clk_125mhz_i) begin
        if (strobe_i) begin
            upd_q <= upd_i;
        end
    end

    assign pending_o = pending_q;
    assign upd_o     = upd_q;

endmodule

`default_nettype wire

/* hdl/stat_pkg.sv */
// statistics collector types

`default_nettype none

`include "stat_consts.svh"

package stat_pkg;

    typedef logic [`STAT_LOCAL_ID_W-1:0] stat_local_id_t;
    typedef logic [`STAT_ID_W-1:0]       stat_id_t;
    typedef logic [`STAT_INC_W-1:0]      stat_inc_t;
    typedef logic [`STAT_COUNT_W-1:0]    stat_count_t;

    // one pending report inside a port slot
    typedef struct packed {
        stat_local_id_t id;
        stat_inc_t      inc;
    } stat_local_upd_t;

    // merged update towards the counter bank
    typedef struct packed {
        stat_id_t  id;
        stat_inc_t inc;
    } stat_update_t;

endpackage

`default_nettype wire

/* hdl/stat_consts.svh */
// statistics collector constants

`ifndef STAT_CONSTS_SVH
`define STAT_CONSTS_SVH

// ########################################
// port and index geometry
// ########################################

// reporting ports
`define STAT_PORT_CNT     4
// statistics per port, global id = port * per_port + local id
`define STAT_PER_PORT     8
`define STAT_LOCAL_ID_W   3
`define STAT_ID_W         5

// ########################################
// data widths and reset timing
// ########################################

`define STAT_INC_W        16
// counters wrap modulo 2^32
`define STAT_COUNT_W      32
`define STAT_SYNC_STAGES  2
// port reset hold after all conditions clear, in cycles
`define STAT_RESET_HOLD   16

`endif
